//--- csr_unit_pkg.sv
`default_nettype none

package csr_unit_pkg;

   // ========================================================================
   // widths and typedefs
   // ========================================================================

   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [11:0]     csr_addr_t;
   typedef logic [2:0]      funct3_t;
   typedef logic [3:0]      cause_t;
   typedef logic [4:0]      bit_cnt_t;
   typedef logic [3:0]      phase_t;
   typedef logic [1:0]      csr_src_t;

   // new bit source for the serial read-modify-write
   localparam csr_src_t CSR_SRC_CSR = 2'b00;
   localparam csr_src_t CSR_SRC_EXT = 2'b01;
   localparam csr_src_t CSR_SRC_SET = 2'b10;
   localparam csr_src_t CSR_SRC_CLR = 2'b11;

   // ========================================================================
   // machine mode CSR map
   // ========================================================================

   localparam csr_addr_t CSR_MSTATUS  = 12'h300;
   localparam csr_addr_t CSR_MIE      = 12'h304;
   localparam csr_addr_t CSR_MTVEC    = 12'h305;
   localparam csr_addr_t CSR_MSCRATCH = 12'h340;
   localparam csr_addr_t CSR_MEPC     = 12'h341;
   localparam csr_addr_t CSR_MCAUSE   = 12'h342;
   localparam csr_addr_t CSR_MTVAL    = 12'h343;

   localparam int     MSTATUS_MIE_BIT = 3;
   localparam int     MIE_MTIE_BIT    = 7;
   localparam cause_t MCAUSE_TIMER    = 4'd7;

   // one select per supported CSR
   typedef struct packed {
      logic mstatus;
      logic mie;
      logic mtvec;
      logic mscratch;
      logic mepc;
      logic mcause;
      logic mtval;
   } csr_sel_t;

   typedef struct packed {
      csr_addr_t addr;
      funct3_t   funct3;
      word_t     operand;
   } csr_req_t;

   typedef struct packed {
      word_t  pc;
      word_t  mtval;
      cause_t cause;
   } trap_req_t;

   typedef struct packed {
      bit_cnt_t cnt;
      phase_t   phase;
   } bit_pos_t;

endpackage

`default_nettype wire

//--- csr_bit_counter.sv
`timescale 1ns/1ns
`default_nettype none

module csr_bit_counter (
   input  wire                   i_clk,
   input  wire                   i_rst_n,
   input  wire                   i_en,
   output csr_unit_pkg::bit_pos_t o_pos
);

   csr_unit_pkg::bit_cnt_t cnt_q;
   csr_unit_pkg::phase_t   phase;

   // ========================================================================
   // bit position
   // ========================================================================

   // wraps from 31 back to 0, so every sweep starts at bit 0
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cnt_q <= '0;
      end else if (i_en) begin
         cnt_q <= cnt_q + csr_unit_pkg::bit_cnt_t'(1);
      end
   end

   // one-hot position inside the current nibble
   always_comb begin
      phase = '0;
      phase[cnt_q[1:0]] = 1'b1;
   end

   // Single bit CSR fields are found by nibble index plus phase,
   // which keeps the compares in the CSR file narrow.
   always_comb begin
      o_pos.cnt   = cnt_q;
      o_pos.phase = phase;
   end

endmodule

`default_nettype wire

//--- csr_addr_decode.sv
`timescale 1ns/1ns
`default_nettype none

module csr_addr_decode (
   input  wire                     i_run,
   input  csr_unit_pkg::csr_addr_t i_addr,
   input  csr_unit_pkg::funct3_t   i_funct3,
   output csr_unit_pkg::csr_sel_t  o_sel,
   output csr_unit_pkg::csr_src_t  o_src,
   output logic                    o_illegal
);

   csr_unit_pkg::csr_sel_t sel;
   logic                   hit;

   // ========================================================================
   // address match
   // ========================================================================

   always_comb begin
      sel = '0;
      case (i_addr)
         csr_unit_pkg::CSR_MSTATUS:  sel.mstatus  = 1'b1;
         csr_unit_pkg::CSR_MIE:      sel.mie      = 1'b1;
         csr_unit_pkg::CSR_MTVEC:    sel.mtvec    = 1'b1;
         csr_unit_pkg::CSR_MSCRATCH: sel.mscratch = 1'b1;
         csr_unit_pkg::CSR_MEPC:     sel.mepc     = 1'b1;
         csr_unit_pkg::CSR_MCAUSE:   sel.mcause   = 1'b1;
         csr_unit_pkg::CSR_MTVAL:    sel.mtval    = 1'b1;
         default:                    sel          = '0;
      endcase
   end

   assign hit = |sel;

   // selects only live while a CSR sweep runs
   assign o_sel     = i_run ? sel : '0;
   assign o_illegal = i_run & ~hit;

   // ========================================================================
   // source mode
   // ========================================================================

   // funct3 bit 2 selects the immediate form and is handled in the sequencer
   always_comb begin
      case (i_funct3[1:0])
         2'd1:    o_src = csr_unit_pkg::CSR_SRC_EXT;
         2'd2:    o_src = csr_unit_pkg::CSR_SRC_SET;
         2'd3:    o_src = csr_unit_pkg::CSR_SRC_CLR;
         default: o_src = csr_unit_pkg::CSR_SRC_CSR;
      endcase
   end

endmodule

`default_nettype wire

//--- csr_file.sv
`timescale 1ns/1ns
`default_nettype none

module csr_file (
   input  wire                    i_clk,
   input  wire                    i_rst_n,
   input  csr_unit_pkg::bit_pos_t i_pos,
   input  csr_unit_pkg::csr_sel_t i_sel,
   input  csr_unit_pkg::csr_src_t i_src,
   input  wire                    i_trap,
   input  wire                    i_pc,
   input  wire                    i_mtval,
   input  wire                    i_d,
   input  wire                    i_mtip,
   input  csr_unit_pkg::cause_t   i_mcause,
   output logic                   o_q,
   output logic                   o_timer_irq_en
);

   logic                 mstatus_mie;
   logic                 mie_mtie;
   logic                 mstatus_rd;
   csr_unit_pkg::word_t  mscratch;
   csr_unit_pkg::word_t  mtvec;
   csr_unit_pkg::word_t  mepc;
   csr_unit_pkg::word_t  mtval;
   logic                 mcause31;
   csr_unit_pkg::cause_t mcause_code;
   logic                 mcause_rd;
   logic                 csr_out;
   logic                 csr_in;
   logic                 timer_trap;
   logic [2:0]           nibble;
   logic                 at_mie;
   logic                 at_mie_pre;
   logic                 at_mtie;
   logic                 at_msb;

   assign nibble = i_pos.cnt[4:2];

   assign at_mie = (nibble == 3'(csr_unit_pkg::MSTATUS_MIE_BIT / 4)) &
                   i_pos.phase[csr_unit_pkg::MSTATUS_MIE_BIT % 4];
   // one bit early so the registered copy lines up with bit 3
   assign at_mie_pre = (nibble == 3'((csr_unit_pkg::MSTATUS_MIE_BIT - 1) / 4)) &
                       i_pos.phase[(csr_unit_pkg::MSTATUS_MIE_BIT - 1) % 4];
   assign at_mtie = (nibble == 3'(csr_unit_pkg::MIE_MTIE_BIT / 4)) &
                    i_pos.phase[csr_unit_pkg::MIE_MTIE_BIT % 4];
   assign at_msb = (nibble == 3'((csr_unit_pkg::XLEN - 1) / 4)) &
                   i_pos.phase[(csr_unit_pkg::XLEN - 1) % 4];

   // ========================================================================
   // serial read path
   // ========================================================================

   // mcause keeps a 4-bit code in nibble 0 and the interrupt flag at bit 31
   assign mcause_rd = (nibble == 3'd0) ? mcause_code[0] :
                      at_msb           ? mcause31 : 1'b0;

   // mie has no read path and always reads zero
   assign csr_out = (i_sel.mstatus  & mstatus_rd) |
                    (i_sel.mtvec    & mtvec[0]) |
                    (i_sel.mscratch & mscratch[0]) |
                    (i_sel.mepc     & mepc[0]) |
                    (i_sel.mcause   & mcause_rd) |
                    (i_sel.mtval    & mtval[0]);

   always_comb begin
      case (i_src)
         csr_unit_pkg::CSR_SRC_EXT: csr_in = i_d;
         csr_unit_pkg::CSR_SRC_SET: csr_in = csr_out | i_d;
         csr_unit_pkg::CSR_SRC_CLR: csr_in = csr_out & ~i_d;
         default:                   csr_in = csr_out;
      endcase
   end

   assign o_q            = csr_out;
   assign o_timer_irq_en = mstatus_mie & mie_mtie;
   assign timer_trap     = i_mtip & o_timer_irq_en;

   // ========================================================================
   // interrupt enables
   // ========================================================================

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         mstatus_mie <= 1'b0;
         mie_mtie    <= 1'b0;
         mstatus_rd  <= 1'b0;
      end else begin
         if (i_sel.mstatus & at_mie) begin
            mstatus_mie <= csr_in;
         end
         if (i_sel.mie & at_mtie) begin
            mie_mtie <= csr_in;
         end
         mstatus_rd <= at_mie_pre & mstatus_mie;
      end
   end

   // ========================================================================
   // data CSRs
   // ========================================================================

   // each register rotates right with the new bit entering at the top
   always_ff @(posedge i_clk) begin
      if (i_sel.mscratch) begin
         mscratch <= {csr_in, mscratch[31:1]};
      end
      if (i_sel.mtvec) begin
         mtvec <= {csr_in, mtvec[31:1]};
      end
      if (i_sel.mepc | i_trap) begin
         mepc <= {i_trap ? i_pc : csr_in, mepc[31:1]};
      end
      if (i_sel.mtval | i_trap) begin
         mtval <= {i_trap ? i_mtval : csr_in, mtval[31:1]};
      end

      // trap cause is taken once at the start of the sweep
      if (i_trap && (i_pos.cnt == '0)) begin
         mcause31    <= timer_trap;
         mcause_code <= timer_trap ? csr_unit_pkg::MCAUSE_TIMER : i_mcause;
      end else if (i_sel.mcause) begin
         if (nibble == 3'd0) begin
            mcause_code <= {csr_in, mcause_code[3:1]};
         end
         if (at_msb) begin
            mcause31 <= csr_in;
         end
      end
   end

endmodule

`default_nettype wire

//--- csr_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module csr_sequencer (
   input  wire                     i_clk,
   input  wire                     i_rst_n,
   input  wire                     i_start,
   input  csr_unit_pkg::csr_req_t  i_req,
   input  wire                     i_trap,
   input  csr_unit_pkg::trap_req_t i_trap_data,
   input  csr_unit_pkg::bit_pos_t  i_pos,
   input  wire                     i_q,
   input  wire                     i_illegal,
   output logic                    o_cnt_en,
   output logic                    o_run_csr,
   output logic                    o_trap_run,
   output logic                    o_d,
   output logic                    o_pc,
   output logic                    o_mtval,
   output csr_unit_pkg::cause_t    o_cause,
   output csr_unit_pkg::csr_addr_t o_addr,
   output csr_unit_pkg::funct3_t   o_funct3,
   output logic                    o_busy,
   output logic                    o_done,
   output logic                    o_illegal,
   output csr_unit_pkg::word_t     o_rdata
);

   typedef enum logic [1:0] {
      IDLE,
      CSR_RUN,
      TRAP_RUN,
      DONE
   } state_t;

   state_t              state_q;
   state_t              state_d;
   logic                running;
   logic                ready;
   logic                take_trap;
   logic                take_start;
   logic                last_bit;
   logic                first_bit;
   csr_unit_pkg::word_t op_sr;
   csr_unit_pkg::word_t pc_sr;
   csr_unit_pkg::word_t mtval_sr;
   csr_unit_pkg::word_t operand;

   assign running    = (state_q == CSR_RUN) | (state_q == TRAP_RUN);
   // a new strobe is accepted in the done cycle as well
   assign ready      = (state_q == IDLE) | (state_q == DONE);
   assign take_trap  = ready & i_trap;
   assign take_start = ready & i_start & ~i_trap;
   assign first_bit  = i_pos.cnt == '0;
   assign last_bit   = i_pos.cnt == csr_unit_pkg::bit_cnt_t'(csr_unit_pkg::XLEN - 1);

   // immediate forms carry a 5-bit uimm, zero extended
   assign operand = i_req.funct3[2] ? csr_unit_pkg::word_t'(i_req.operand[4:0]) :
                                      i_req.operand;

   // ========================================================================
   // state machine
   // ========================================================================

   always_comb begin
      state_d = state_q;
      case (state_q)
         CSR_RUN, TRAP_RUN: begin
            if (last_bit) begin
               state_d = DONE;
            end
         end
         default: begin
            if (take_trap) begin
               state_d = TRAP_RUN;
            end else if (take_start) begin
               state_d = CSR_RUN;
            end else begin
               state_d = IDLE;
            end
         end
      endcase
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state_q   <= IDLE;
         o_illegal <= 1'b0;
      end else begin
         state_q <= state_d;
         if (running & first_bit) begin
            o_illegal <= i_illegal;
         end
      end
   end

   // ========================================================================
   // serializers
   // ========================================================================

   always_ff @(posedge i_clk) begin
      if (take_trap) begin
         pc_sr    <= i_trap_data.pc;
         mtval_sr <= i_trap_data.mtval;
         o_cause  <= i_trap_data.cause;
      end else if (take_start) begin
         op_sr    <= operand;
         o_addr   <= i_req.addr;
         o_funct3 <= i_req.funct3;
      end else if (running) begin
         op_sr    <= {1'b0, op_sr[31:1]};
         pc_sr    <= {1'b0, pc_sr[31:1]};
         mtval_sr <= {1'b0, mtval_sr[31:1]};
      end

      // old value arrives lsb first
      if (running) begin
         o_rdata <= {i_q, o_rdata[31:1]};
      end
   end

   assign o_d        = op_sr[0];
   assign o_pc       = pc_sr[0];
   assign o_mtval    = mtval_sr[0];
   assign o_cnt_en   = running;
   assign o_run_csr  = state_q == CSR_RUN;
   assign o_trap_run = state_q == TRAP_RUN;
   assign o_busy     = running;
   assign o_done     = state_q == DONE;

endmodule

`default_nettype wire

//--- csr_unit.sv
`timescale 1ns/1ns
`default_nettype none

module csr_unit (
   input  wire                     i_clk,
   input  wire                     i_rst_n,
   input  wire                     i_start,
   input  csr_unit_pkg::csr_req_t  i_req,
   input  wire                     i_trap,
   input  csr_unit_pkg::trap_req_t i_trap_data,
   input  wire                     i_mtip,
   output logic                    o_busy,
   output logic                    o_done,
   output csr_unit_pkg::word_t     o_rdata,
   output logic                    o_illegal,
   output logic                    o_timer_irq_en
);

   logic                    cnt_en;
   logic                    run_csr;
   logic                    trap_run;
   logic                    ser_d;
   logic                    ser_pc;
   logic                    ser_mtval;
   logic                    ser_q;
   logic                    dec_illegal;
   csr_unit_pkg::cause_t    cause;
   csr_unit_pkg::csr_addr_t addr;
   csr_unit_pkg::funct3_t   funct3;
   csr_unit_pkg::bit_pos_t  pos;
   csr_unit_pkg::csr_sel_t  sel;
   csr_unit_pkg::csr_src_t  src;

   csr_sequencer seq_i (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_start     (i_start),
      .i_req       (i_req),
      .i_trap      (i_trap),
      .i_trap_data (i_trap_data),
      .i_pos       (pos),
      .i_q         (ser_q),
      .i_illegal   (dec_illegal),
      .o_cnt_en    (cnt_en),
      .o_run_csr   (run_csr),
      .o_trap_run  (trap_run),
      .o_d         (ser_d),
      .o_pc        (ser_pc),
      .o_mtval     (ser_mtval),
      .o_cause     (cause),
      .o_addr      (addr),
      .o_funct3    (funct3),
      .o_busy      (o_busy),
      .o_done      (o_done),
      .o_illegal   (o_illegal),
      .o_rdata     (o_rdata)
   );

   csr_bit_counter cnt_i (
      .i_clk   (i_clk),
      .i_rst_n (i_rst_n),
      .i_en    (cnt_en),
      .o_pos   (pos)
   );

   csr_addr_decode dec_i (
      .i_run     (run_csr),
      .i_addr    (addr),
      .i_funct3  (funct3),
      .o_sel     (sel),
      .o_src     (src),
      .o_illegal (dec_illegal)
   );

   csr_file file_i (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .i_pos          (pos),
      .i_sel          (sel),
      .i_src          (src),
      .i_trap         (trap_run),
      .i_pc           (ser_pc),
      .i_mtval        (ser_mtval),
      .i_d            (ser_d),
      .i_mtip         (i_mtip),
      .i_mcause       (cause),
      .o_q            (ser_q),
      .o_timer_irq_en (o_timer_irq_en)
   );

endmodule

`default_nettype wire

//--- csr_unit_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module csr_unit_asserts (
   input wire i_clk,
   input wire i_rst_n,
   input wire i_busy,
   input wire i_done,
   input wire i_timer_irq_en
);

   logic [5:0] busy_len;

   // cycles spent busy in the current sweep
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         busy_len <= '0;
      end else if (i_busy) begin
         busy_len <= busy_len + 6'd1;
      end else begin
         busy_len <= '0;
      end
   end

   // ========================================================================
   // sweep length and done pulse
   // ========================================================================

   busy_max_a : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_busy |-> busy_len < 6'd32)
      else $error("o_busy held high for more than 32 cycles");

   busy_len_a : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $fell(i_busy) |-> busy_len == 6'd32)
      else $error("o_busy fell after %0d cycles instead of 32", busy_len);

   done_follows_busy_a : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_done |-> $fell(i_busy))
      else $error("o_done pulsed without a fall of o_busy");

   done_width_a : assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_done |=> !i_done)
      else $error("o_done lasted longer than one cycle");

   // outputs come out of reset quiet and known
   reset_state_a : assert property (@(posedge i_clk)
      $rose(i_rst_n) |-> !i_busy && !i_done && !i_timer_irq_en &&
                         !$isunknown({i_busy, i_done, i_timer_irq_en}))
      else $error("o_busy, o_done or o_timer_irq_en not low after reset");

endmodule

bind csr_unit csr_unit_asserts asserts_i (
   .i_clk          (i_clk),
   .i_rst_n        (i_rst_n),
   .i_busy         (o_busy),
   .i_done         (o_done),
   .i_timer_irq_en (o_timer_irq_en)
);

`default_nettype wire

//--- tb_csr_unit.sv
`timescale 1ns/1ns
`default_nettype none

module tb_csr_unit;

   localparam int CLK_PERIOD   = 10;
   localparam int RESET_CYCLES = 16;
   localparam int OP_CYCLES    = 40;
   // CSR ops and traps issued by the tests below
   localparam int NUM_OPS      = 46;
   localparam int MARGIN       = 200;

   logic                    i_clk;
   logic                    i_rst_n;
   logic                    i_start;
   logic                    i_trap;
   logic                    i_mtip;
   csr_unit_pkg::csr_req_t  i_req;
   csr_unit_pkg::trap_req_t i_trap_data;
   logic                    o_busy;
   logic                    o_done;
   logic                    o_illegal;
   logic                    o_timer_irq_en;
   csr_unit_pkg::word_t     o_rdata;

   // model slots in the order mstatus, mie, mtvec, mscratch, mepc, mcause, mtval
   csr_unit_pkg::word_t model_q [7];
   logic [6:0]          model_known;
   logic                model_mtie;
   logic [31:0]         lfsr_q;
   int                  error_count;
   int                  check_count;
   int                  test_count;
   int                  failed_tests;

   csr_unit dut_i (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .i_start        (i_start),
      .i_req          (i_req),
      .i_trap         (i_trap),
      .i_trap_data    (i_trap_data),
      .i_mtip         (i_mtip),
      .o_busy         (o_busy),
      .o_done         (o_done),
      .o_rdata        (o_rdata),
      .o_illegal      (o_illegal),
      .o_timer_irq_en (o_timer_irq_en)
   );

   always #(CLK_PERIOD / 2) i_clk = ~i_clk;

   initial begin
      #((RESET_CYCLES + NUM_OPS * OP_CYCLES + MARGIN) * CLK_PERIOD);
      $display("watchdog expired, the tests did not finish in time");
      $display("Testbench failed");
      $finish;
   end

   // ========================================================================
   // random data and reference model
   // ========================================================================

   // taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
   endfunction

   task automatic next_random(input int nbits, output csr_unit_pkg::word_t value);
      value = '0;
      for (int i = 0; i < nbits; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         value  = {value[30:0], lfsr_q[0]};
      end
   endtask

   function automatic int csr_index(input csr_unit_pkg::csr_addr_t addr);
      case (addr)
         csr_unit_pkg::CSR_MSTATUS:  return 0;
         csr_unit_pkg::CSR_MIE:      return 1;
         csr_unit_pkg::CSR_MTVEC:    return 2;
         csr_unit_pkg::CSR_MSCRATCH: return 3;
         csr_unit_pkg::CSR_MEPC:     return 4;
         csr_unit_pkg::CSR_MCAUSE:   return 5;
         csr_unit_pkg::CSR_MTVAL:    return 6;
         default:                    return -1;
      endcase
   endfunction

   function automatic logic model_irq_en();
      return model_q[0][csr_unit_pkg::MSTATUS_MIE_BIT] & model_mtie;
   endfunction

   task automatic model_write(input csr_unit_pkg::csr_addr_t addr,
                              input csr_unit_pkg::funct3_t f3,
                              input csr_unit_pkg::word_t operand);
      int                  idx;
      csr_unit_pkg::word_t op;
      csr_unit_pkg::word_t nv;
      idx = csr_index(addr);
      op  = f3[2] ? {27'b0, operand[4:0]} : operand;
      if (idx >= 0) begin
         case (f3[1:0])
            2'd1:    nv = op;
            2'd2:    nv = model_q[idx] | op;
            2'd3:    nv = model_q[idx] & ~op;
            default: nv = model_q[idx];
         endcase
         case (idx)
            0:       model_q[0] = nv & (32'd1 << csr_unit_pkg::MSTATUS_MIE_BIT);
            1:       model_mtie = nv[csr_unit_pkg::MIE_MTIE_BIT];
            5:       model_q[5] = nv & 32'h8000_000f;
            default: model_q[idx] = nv;
         endcase
         if (f3[1:0] == 2'd1) begin
            model_known[idx] = 1'b1;
         end
      end
   endtask

   task automatic model_trap(input csr_unit_pkg::word_t pc,
                             input csr_unit_pkg::word_t mtval,
                             input csr_unit_pkg::cause_t cause);
      model_q[4] = pc;
      model_q[6] = mtval;
      if (i_mtip && model_irq_en()) begin
         model_q[5] = {1'b1, 27'b0, csr_unit_pkg::MCAUSE_TIMER};
      end else begin
         model_q[5] = {28'b0, cause};
      end
      model_known[6:4] = 3'b111;
   endtask

   // ========================================================================
   // checks and stimulus
   // ========================================================================

   task automatic check_word(input string name, input csr_unit_pkg::word_t expected,
                             input csr_unit_pkg::word_t actual);
      check_count++;
      assert (actual === expected) else begin
         $display("Mismatch at %0t: %s expected %h, actual %h",
                  $time, name, expected, actual);
         error_count++;
      end
   endtask

   task automatic wait_done();
      int cycles;
      cycles = 0;
      while (!o_done && cycles < OP_CYCLES) begin
         @(negedge i_clk);
         cycles++;
      end
      if (!o_done) begin
         $display("Error at %0t: o_done did not pulse within %0d cycles of the strobe",
                  $time, OP_CYCLES);
         error_count++;
      end
   endtask

   task automatic csr_op(input csr_unit_pkg::csr_addr_t addr,
                         input csr_unit_pkg::funct3_t f3,
                         input csr_unit_pkg::word_t operand);
      int                  idx;
      logic                known;
      csr_unit_pkg::word_t expected;
      idx = csr_index(addr);
      if (idx >= 0) begin
         expected = model_q[idx];
         known    = model_known[idx];
      end else begin
         expected = '0;
         known    = 1'b1;
      end
      @(negedge i_clk);
      i_req.addr    = addr;
      i_req.funct3  = f3;
      i_req.operand = operand;
      i_start       = 1'b1;
      @(negedge i_clk);
      i_start = 1'b0;
      wait_done();
      model_write(addr, f3, operand);
      if (known) begin
         check_word("o_rdata", expected, o_rdata);
      end
      check_word("o_illegal", csr_unit_pkg::word_t'(idx < 0), csr_unit_pkg::word_t'(o_illegal));
      check_word("o_timer_irq_en", csr_unit_pkg::word_t'(model_irq_en()),
                 csr_unit_pkg::word_t'(o_timer_irq_en));
   endtask

   task automatic trap_op(input csr_unit_pkg::word_t pc, input csr_unit_pkg::word_t mtval,
                          input csr_unit_pkg::cause_t cause);
      @(negedge i_clk);
      i_trap_data.pc    = pc;
      i_trap_data.mtval = mtval;
      i_trap_data.cause = cause;
      i_trap            = 1'b1;
      @(negedge i_clk);
      i_trap = 1'b0;
      wait_done();
      model_trap(pc, mtval, cause);
   endtask

   task automatic finish_test(input string name, input int errors_before);
      test_count++;
      if (error_count == errors_before) begin
         $display("test %0d %s: ok", test_count, name);
      end else begin
         failed_tests++;
         $display("test %0d %s: FAILED with %0d errors", test_count, name,
                  error_count - errors_before);
      end
   endtask

   // ========================================================================
   // test sequence
   // ========================================================================

   initial begin
      int                  errors_before;
      csr_unit_pkg::word_t value;
      csr_unit_pkg::word_t pc;
      csr_unit_pkg::word_t tval;
      csr_unit_pkg::word_t code;
      i_clk       = 1'b0;
      i_rst_n     = 1'b0;
      i_start     = 1'b0;
      i_trap      = 1'b0;
      i_mtip      = 1'b0;
      i_req       = '0;
      i_trap_data = '0;
      lfsr_q      = 32'hfd6f;
      error_count  = 0;
      check_count  = 0;
      test_count   = 0;
      failed_tests = 0;
      foreach (model_q[i]) begin
         model_q[i] = '0;
      end
      // only the enable bits have a reset value
      model_known = 7'b000_0011;
      model_mtie  = 1'b0;
      repeat (RESET_CYCLES) @(negedge i_clk);
      i_rst_n = 1'b1;

      errors_before = error_count;
      for (int i = 0; i < 4; i++) begin
         next_random(32, value);
         csr_op(csr_unit_pkg::CSR_MSCRATCH, 3'd1, value);
      end
      for (int i = 0; i < 4; i++) begin
         next_random(32, value);
         csr_op(csr_unit_pkg::CSR_MTVEC, 3'd1, value);
      end
      csr_op(csr_unit_pkg::CSR_MTVEC, 3'd2, '0);
      finish_test("csrrw mscratch and mtvec", errors_before);

      // csrrs, csrrc, csrrsi and csrrci in turn
      errors_before = error_count;
      for (int i = 0; i < 8; i++) begin
         next_random(32, value);
         csr_op(csr_unit_pkg::CSR_MSCRATCH, {i[1], 1'b1, i[0]}, value);
      end
      csr_op(csr_unit_pkg::CSR_MSCRATCH, 3'd2, '0);
      finish_test("set and clear on mscratch", errors_before);

      errors_before = error_count;
      csr_op(csr_unit_pkg::CSR_MSTATUS, 3'd1, 32'hffff_ffff);
      csr_op(csr_unit_pkg::CSR_MIE, 3'd1, 32'h80);
      csr_op(csr_unit_pkg::CSR_MSTATUS, 3'd2, '0);
      csr_op(csr_unit_pkg::CSR_MIE, 3'd1, 32'h80);
      csr_op(csr_unit_pkg::CSR_MSTATUS, 3'd7, 32'hffff_ffe8);
      csr_op(csr_unit_pkg::CSR_MSTATUS, 3'd6, 32'h8);
      csr_op(csr_unit_pkg::CSR_MIE, 3'd1, '0);
      csr_op(csr_unit_pkg::CSR_MSTATUS, 3'd1, '0);
      finish_test("interrupt enables", errors_before);

      // timer pending but masked, so the given cause is kept
      errors_before = error_count;
      i_mtip = 1'b1;
      for (int i = 0; i < 2; i++) begin
         next_random(32, pc);
         next_random(32, tval);
         next_random(4, code);
         trap_op(pc, tval, code[3:0]);
         csr_op(csr_unit_pkg::CSR_MEPC, 3'd2, '0);
         csr_op(csr_unit_pkg::CSR_MTVAL, 3'd2, '0);
         csr_op(csr_unit_pkg::CSR_MCAUSE, 3'd2, '0);
      end
      finish_test("trap with interrupts disabled", errors_before);

      errors_before = error_count;
      csr_op(csr_unit_pkg::CSR_MSTATUS, 3'd1, 32'h8);
      csr_op(csr_unit_pkg::CSR_MIE, 3'd1, 32'h80);
      next_random(32, pc);
      next_random(32, tval);
      next_random(4, code);
      trap_op(pc, tval, code[3:0]);
      csr_op(csr_unit_pkg::CSR_MCAUSE, 3'd2, '0);
      csr_op(csr_unit_pkg::CSR_MEPC, 3'd2, '0);
      csr_op(csr_unit_pkg::CSR_MTVAL, 3'd2, '0);
      csr_op(csr_unit_pkg::CSR_MSTATUS, 3'd1, '0);
      csr_op(csr_unit_pkg::CSR_MIE, 3'd1, '0);
      i_mtip = 1'b0;
      finish_test("timer interrupt trap", errors_before);

      errors_before = error_count;
      next_random(32, value);
      csr_op(csr_unit_pkg::CSR_MSCRATCH, 3'd1, value);
      next_random(32, value);
      csr_op(12'h7c0, 3'd1, value);
      csr_op(12'h301, 3'd6, 32'h1f);
      csr_op(csr_unit_pkg::CSR_MSCRATCH, 3'd2, '0);
      finish_test("unsupported address", errors_before);

      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               test_count, failed_tests, check_count, error_count);
      if (error_count == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- csr_unit.f
csr_unit_pkg.sv
csr_bit_counter.sv
csr_addr_decode.sv
csr_file.sv
csr_sequencer.sv
csr_unit.sv
csr_unit_asserts.sv
tb_csr_unit.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the csr_unit testbench with verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_csr_unit -f csr_unit.f &&
   ./obj_dir/Vtb_csr_unit > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q -s -e "Testbench failed" -e "%Error" sim.log && exit 1
grep -q -s "Testbench passed" sim.log || exit 1
exit 0
